// File: project.f
+incdir+design
design/island_pkg.sv
design/bit_sync.sv
design/addr_decoder.sv
design/rr_arbiter.sv
design/req_router.sv
design/security_island.sv
test/tb_security_island.sv

// File: Makefile
# Verilator build and run for the security island testbench

SIM = obj_dir/Vtb_security_island

.PHONY: all run clean

all: run

$(SIM): project.f $(wildcard design/*.sv design/*.svh test/*.sv)
	verilator --binary --timing -f project.f --top-module tb_security_island \
		-o Vtb_security_island

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: test/tb_security_island.sv
// Security island testbench
// Drives both initiators, models the host and cluster targets
// and checks responses against a reference address map and memory

`default_nettype none

`include "island_defines.svh"

module tb_security_island;

   timeunit 1ns;
   timeprecision 100ps;

   import island_pkg::*;

   localparam int TgtHost   = 0;
   localparam int TgtCls    = 1;
   localparam int TgtNone   = 2;
   localparam int NumTxn    = 60;
   localparam int MaxCycles = 20 * NumTxn + 100;

   typedef struct {
      int    tgt;
      logic  we;
      addr_t addr;
      data_t wdata;
      data_t rdata;
      logic  err;
      int    host_n;
      int    cls_n;
   } exp_t;

   logic        clk_i, rst_i, fetch_en_i, irq_i, irq_o;
   logic  [1:0] init_req_i, init_we_i, init_gnt_o, init_rsp_o, init_err_o;
   addr_t [1:0] init_addr_i;
   data_t [1:0] init_wdata_i;
   data_t       init_rdata_o;
   logic        host_req_o, host_we_o, host_rsp_i;
   addr_t       host_addr_o;
   data_t       host_wdata_o, host_rdata_i;
   logic        cls_req_o, cls_we_o, cls_rsp_i;
   addr_t       cls_addr_o;
   data_t       cls_wdata_o, cls_rdata_i;

   int    errors = 0;
   int    checks = 0;
   int    cycles = 0;
   int    host_cnt = 0;
   int    cls_cnt = 0;
   logic  host_last_we, cls_last_we;
   addr_t host_last_addr, cls_last_addr;
   data_t host_last_wdata, cls_last_wdata;
   data_t ref_mem[addr_t];
   data_t host_mem[addr_t];
   data_t cls_mem[addr_t];
   exp_t  exp_q0[$];
   exp_t  exp_q1[$];
   logic  alt_mode = 1'b0;
   logic  [1:0] last_gnt = 2'b00;

   security_island i_security_island (.*);

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic int expected_target(input addr_t a);
      if (a >= `ISL_HOST_BASE && a < `ISL_HOST_END) return TgtHost;
      if (a >= `ISL_CLS_BASE && a < `ISL_CLS_END) return TgtCls;
      return TgtNone;
   endfunction

   // Contents of a location never written
   function automatic data_t fill_word(input addr_t a);
      return a ^ 32'h6D2B_79F5;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %s got=%h exp=%h at %0t", name, got, exp, $time);
      end
   endtask

   //////////////////////////////////////////////////
   // Initiator and target models
   //////////////////////////////////////////////////

   task automatic run_txn(input int n, input logic we, input addr_t addr, input data_t wdata);
      exp_t e;
      @(posedge clk_i);
      init_req_i[n]   <= 1'b1;
      init_we_i[n]    <= we;
      init_addr_i[n]  <= addr;
      init_wdata_i[n] <= wdata;
      do @(negedge clk_i); while (!init_gnt_o[n]);
      e.tgt    = expected_target(addr);
      e.we     = we;
      e.addr   = addr;
      e.wdata  = wdata;
      e.err    = (e.tgt == TgtNone);
      e.rdata  = '0;
      e.host_n = host_cnt;
      e.cls_n  = cls_cnt;
      if (e.tgt != TgtNone) begin
         if (we) begin
            ref_mem[addr] = wdata;
         end else begin
            e.rdata = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
         end
      end
      if (n == 0) exp_q0.push_back(e);
      else exp_q1.push_back(e);
      @(posedge clk_i);
      init_req_i[n] <= 1'b0;
      do @(negedge clk_i); while (!init_rsp_o[n]);
   endtask

   // Host target answering after 1 to 5 cycles
   initial begin : host_target
      int    d;
      data_t rd;
      forever begin
         @(negedge clk_i);
         if (host_req_o) begin
            host_cnt++;
            host_last_we    = host_we_o;
            host_last_addr  = host_addr_o;
            host_last_wdata = host_wdata_o;
            rd = '0;
            if (host_we_o) host_mem[host_addr_o] = host_wdata_o;
            else if (host_mem.exists(host_addr_o)) rd = host_mem[host_addr_o];
            else rd = fill_word(host_addr_o);
            d = $urandom_range(1, 5);
            repeat (d) @(posedge clk_i);
            host_rsp_i   <= 1'b1;
            host_rdata_i <= rd;
            @(posedge clk_i);
            host_rsp_i   <= 1'b0;
            host_rdata_i <= '0;
         end
      end
   end

   // Cluster target with the same behaviour
   initial begin : cls_target
      int    d;
      data_t rd;
      forever begin
         @(negedge clk_i);
         if (cls_req_o) begin
            cls_cnt++;
            cls_last_we    = cls_we_o;
            cls_last_addr  = cls_addr_o;
            cls_last_wdata = cls_wdata_o;
            rd = '0;
            if (cls_we_o) cls_mem[cls_addr_o] = cls_wdata_o;
            else if (cls_mem.exists(cls_addr_o)) rd = cls_mem[cls_addr_o];
            else rd = fill_word(cls_addr_o);
            d = $urandom_range(1, 5);
            repeat (d) @(posedge clk_i);
            cls_rsp_i   <= 1'b1;
            cls_rdata_i <= rd;
            @(posedge clk_i);
            cls_rsp_i   <= 1'b0;
            cls_rdata_i <= '0;
         end
      end
   end

   //////////////////////////////////////////////////
   // Response compare
   //////////////////////////////////////////////////

   always @(negedge clk_i) begin : compare
      exp_t e;
      if (alt_mode && |init_gnt_o) begin
         if (last_gnt != 2'b00) check("init_gnt_o", 32'(init_gnt_o), 32'(last_gnt ^ 2'b11));
         last_gnt = init_gnt_o;
      end
      for (int n = 0; n < 2; n++) begin
         if (init_rsp_o[n]) begin
            if ((n == 0 && exp_q0.size() == 0) || (n == 1 && exp_q1.size() == 0)) begin
               errors++;
               $display("Response on initiator %0d with no request pending", n);
            end else begin
               e = (n == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
               check("init_rdata_o", init_rdata_o, e.rdata);
               check("init_err_o", 32'(init_err_o[n]), 32'(e.err));
               check("host_req_o count", host_cnt, e.host_n + (e.tgt == TgtHost ? 1 : 0));
               check("cls_req_o count", cls_cnt, e.cls_n + (e.tgt == TgtCls ? 1 : 0));
               if (e.tgt == TgtHost) begin
                  check("host_addr_o", host_last_addr, e.addr);
                  check("host_we_o", 32'(host_last_we), 32'(e.we));
                  if (e.we) check("host_wdata_o", host_last_wdata, e.wdata);
               end else if (e.tgt == TgtCls) begin
                  check("cls_addr_o", cls_last_addr, e.addr);
                  check("cls_we_o", 32'(cls_last_we), 32'(e.we));
                  if (e.we) check("cls_wdata_o", cls_last_wdata, e.wdata);
               end
            end
         end
      end
   end

   initial begin : timeout
      while (cycles < MaxCycles) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("Simulation failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic region_test(input addr_t base, input addr_t span);
      addr_t a[8];
      for (int i = 0; i < 8; i++) begin
         a[i] = base + (($urandom % span) & ~32'h3);
         run_txn(i % 2, 1'b1, a[i], $urandom);
      end
      for (int i = 7; i >= 0; i--) begin
         run_txn(i % 2, 1'b0, a[i], '0);
      end
   endtask

   task automatic alt_stream(input int n);
      addr_t a;
      for (int i = 0; i < 10; i++) begin
         if ($urandom % 2) a = `ISL_HOST_BASE + (($urandom % 32'h100) & ~32'h3);
         else a = `ISL_CLS_BASE + (($urandom % 32'h100) & ~32'h3);
         run_txn(n, 1'($urandom % 2), a, $urandom);
      end
   endtask

   initial begin : main
      logic irq_hist[$];
      logic r;
      int   wait_n;
      addr_t bad[6];
      void'($urandom(98669));
      rst_i        = 1'b1;
      fetch_en_i   = 1'b0;
      irq_i        = 1'b0;
      init_req_i   = '0;
      init_we_i    = '0;
      init_addr_i  = '0;
      init_wdata_i = '0;
      host_rsp_i   = 1'b0;
      host_rdata_i = '0;
      cls_rsp_i    = 1'b0;
      cls_rdata_i  = '0;
      repeat (3) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
      check("init_gnt_o", 32'(init_gnt_o), 32'h0);
      check("init_rsp_o", 32'(init_rsp_o), 32'h0);
      check("host_req_o", 32'(host_req_o), 32'h0);
      check("cls_req_o", 32'(cls_req_o), 32'h0);
      check("irq_o", 32'(irq_o), 32'h0);

      // Interrupt synchronizer delay
      irq_hist = '{1'b0, 1'b0, 1'b0};
      for (int i = 0; i < 40; i++) begin
         r = 1'($urandom % 2);
         @(posedge clk_i);
         irq_i <= r;
         irq_hist.push_back(r);
         @(negedge clk_i);
         check("irq_o", 32'(irq_o), 32'(irq_hist[irq_hist.size() - 4]));
      end

      // Fetch enable gating
      fork
         run_txn(0, 1'b1, `ISL_HOST_BASE + 32'h40, 32'hCAFE_0001);
         run_txn(1, 1'b1, `ISL_CLS_BASE + 32'h40, 32'hCAFE_0002);
         begin
            repeat (8) begin
               @(negedge clk_i);
               check("init_gnt_o", 32'(init_gnt_o), 32'h0);
               check("host_req_o", 32'(host_req_o), 32'h0);
               check("cls_req_o", 32'(cls_req_o), 32'h0);
            end
            @(posedge clk_i);
            fetch_en_i <= 1'b1;
            wait_n = 0;
            do begin
               @(negedge clk_i);
               wait_n++;
            end while (init_gnt_o == 2'b00 && wait_n < 20);
            check("fetch enable to grant", wait_n, 4);
         end
      join

      region_test(`ISL_HOST_BASE, 32'h0000_0400);
      region_test(`ISL_CLS_BASE, 32'h0000_0400);

      bad = '{32'h0000_0000, 32'h0000_FFFC, 32'hA000_0000,
              32'hA0FF_FFFC, 32'hB000_0000, 32'hFFFF_FFFC};
      for (int i = 0; i < 6; i++) begin
         run_txn(i % 2, 1'($urandom % 2), bad[i], $urandom);
      end

      // Both initiators held busy
      alt_mode = 1'b1;
      last_gnt = 2'b00;
      fork
         alt_stream(0);
         alt_stream(1);
      join
      alt_mode = 1'b0;

      repeat (5) @(negedge clk_i);
      if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
         errors++;
         $display("Requests left without a response");
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: design/security_island.sv
// Security island top level
// Synchronizes fetch enable and interrupt into the clock domain
// and routes root-of-trust requests to the host or cluster port

`default_nettype none

`include "island_defines.svh"

module security_island (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic                                  fetch_en_i,
   input  logic                                  irq_i,
   output logic                                  irq_o,
   // Initiators
   input  logic [`ISL_NUM_INIT-1:0]              init_req_i,
   input  logic [`ISL_NUM_INIT-1:0]              init_we_i,
   input  island_pkg::addr_t [`ISL_NUM_INIT-1:0] init_addr_i,
   input  island_pkg::data_t [`ISL_NUM_INIT-1:0] init_wdata_i,
   output logic [`ISL_NUM_INIT-1:0]              init_gnt_o,
   output logic [`ISL_NUM_INIT-1:0]              init_rsp_o,
   output logic [`ISL_NUM_INIT-1:0]              init_err_o,
   output island_pkg::data_t                     init_rdata_o,
   // Host port
   output logic                                  host_req_o,
   output logic                                  host_we_o,
   output island_pkg::addr_t                     host_addr_o,
   output island_pkg::data_t                     host_wdata_o,
   input  logic                                  host_rsp_i,
   input  island_pkg::data_t                     host_rdata_i,
   // Cluster port
   output logic                                  cls_req_o,
   output logic                                  cls_we_o,
   output island_pkg::addr_t                     cls_addr_o,
   output island_pkg::data_t                     cls_wdata_o,
   input  logic                                  cls_rsp_i,
   input  island_pkg::data_t                     cls_rdata_i
);

   logic fetch_en_sync;

   //////////////////////////////////////////////////
   // Input synchronizers
   //////////////////////////////////////////////////

   bit_sync #(
      .Stages     ( `ISL_SYNC_STAGES ),
      .ResetValue ( 1'b0             )
   ) i_fetch_en_sync (
      .clk_i ( clk_i         ),
      .rst_i ( rst_i         ),
      .d_i   ( fetch_en_i    ),
      .q_o   ( fetch_en_sync )
   );

   bit_sync #(
      .Stages     ( `ISL_SYNC_STAGES ),
      .ResetValue ( 1'b0             )
   ) i_irq_sync (
      .clk_i ( clk_i ),
      .rst_i ( rst_i ),
      .d_i   ( irq_i ),
      .q_o   ( irq_o )
   );

   //////////////////////////////////////////////////
   // Router
   //////////////////////////////////////////////////

   req_router i_req_router (
      .clk_i        ( clk_i         ),
      .rst_i        ( rst_i         ),
      .fetch_en_i   ( fetch_en_sync ),
      .init_req_i   ( init_req_i    ),
      .init_we_i    ( init_we_i     ),
      .init_addr_i  ( init_addr_i   ),
      .init_wdata_i ( init_wdata_i  ),
      .init_gnt_o   ( init_gnt_o    ),
      .init_rsp_o   ( init_rsp_o    ),
      .init_err_o   ( init_err_o    ),
      .init_rdata_o ( init_rdata_o  ),
      .host_req_o   ( host_req_o    ),
      .host_we_o    ( host_we_o     ),
      .host_addr_o  ( host_addr_o   ),
      .host_wdata_o ( host_wdata_o  ),
      .host_rsp_i   ( host_rsp_i    ),
      .host_rdata_i ( host_rdata_i  ),
      .cls_req_o    ( cls_req_o     ),
      .cls_we_o     ( cls_we_o      ),
      .cls_addr_o   ( cls_addr_o    ),
      .cls_wdata_o  ( cls_wdata_o   ),
      .cls_rsp_i    ( cls_rsp_i     ),
      .cls_rdata_i  ( cls_rdata_i   )
   );

endmodule

`default_nettype wire

// File: design/req_router.sv
// Request router
// Arbitrates the root-of-trust initiators, routes one request
// at a time to the host or cluster port and returns a one-cycle
// response pulse to the initiator that issued it

`default_nettype none

`include "island_defines.svh"

module req_router (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic                                  fetch_en_i,
   // Initiators
   input  logic [`ISL_NUM_INIT-1:0]              init_req_i,
   input  logic [`ISL_NUM_INIT-1:0]              init_we_i,
   input  island_pkg::addr_t [`ISL_NUM_INIT-1:0] init_addr_i,
   input  island_pkg::data_t [`ISL_NUM_INIT-1:0] init_wdata_i,
   output logic [`ISL_NUM_INIT-1:0]              init_gnt_o,
   output logic [`ISL_NUM_INIT-1:0]              init_rsp_o,
   output logic [`ISL_NUM_INIT-1:0]              init_err_o,
   output island_pkg::data_t                     init_rdata_o,
   // Host port
   output logic                                  host_req_o,
   output logic                                  host_we_o,
   output island_pkg::addr_t                     host_addr_o,
   output island_pkg::data_t                     host_wdata_o,
   input  logic                                  host_rsp_i,
   input  island_pkg::data_t                     host_rdata_i,
   // Cluster port
   output logic                                  cls_req_o,
   output logic                                  cls_we_o,
   output island_pkg::addr_t                     cls_addr_o,
   output island_pkg::data_t                     cls_wdata_o,
   input  logic                                  cls_rsp_i,
   input  island_pkg::data_t                     cls_rdata_i
);

   import island_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT,
      ST_RESP
   } state_e;

   state_e    state_q;
   logic      arb_en;
   init_idx_t win_idx;
   tgt_sel_e  win_sel;
   logic      tgt_rsp;

   // Latched transaction
   init_idx_t idx_q;
   logic      we_q;
   addr_t     addr_q;
   data_t     wdata_q;
   tgt_sel_e  sel_q;
   data_t     rdata_q;

   //////////////////////////////////////////////////
   // Arbitration and decode
   //////////////////////////////////////////////////

   // Single outstanding, nothing before fetch enable
   assign arb_en = (state_q == ST_IDLE) && fetch_en_i;

   rr_arbiter #(
      .NumReq ( `ISL_NUM_INIT )
   ) i_rr_arbiter (
      .clk_i  ( clk_i      ),
      .rst_i  ( rst_i      ),
      .en_i   ( arb_en     ),
      .req_i  ( init_req_i ),
      .gnt_o  ( init_gnt_o )
   );

   always_comb begin
      win_idx = '0;
      for (int i = 0; i < `ISL_NUM_INIT; i++) begin
         if (init_gnt_o[i]) begin
            win_idx = init_idx_t'(i);
         end
      end
   end

   addr_decoder i_addr_decoder (
      .addr_i ( init_addr_i[win_idx] ),
      .sel_o  ( win_sel              )
   );

   //////////////////////////////////////////////////
   // Transaction FSM
   //////////////////////////////////////////////////

   assign tgt_rsp = ((sel_q == TGT_HOST) && host_rsp_i) ||
                    ((sel_q == TGT_CLS) && cls_rsp_i);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
      end else begin
         case (state_q)
            ST_IDLE: begin
               // Unmapped requests answer at once
               if (|init_gnt_o) begin
                  state_q <= (win_sel == TGT_NONE) ? ST_RESP : ST_WAIT;
               end
            end
            ST_WAIT: begin
               if (tgt_rsp) begin
                  state_q <= ST_RESP;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (|init_gnt_o) begin
         idx_q   <= win_idx;
         we_q    <= init_we_i[win_idx];
         addr_q  <= init_addr_i[win_idx];
         wdata_q <= init_wdata_i[win_idx];
         sel_q   <= win_sel;
         rdata_q <= '0;
      end else if ((state_q == ST_WAIT) && tgt_rsp) begin
         rdata_q <= (sel_q == TGT_HOST) ? host_rdata_i : cls_rdata_i;
      end
   end

   // Target request level held until the target answers
   assign host_req_o   = (state_q == ST_WAIT) && (sel_q == TGT_HOST);
   assign host_we_o    = we_q;
   assign host_addr_o  = addr_q;
   assign host_wdata_o = wdata_q;

   assign cls_req_o    = (state_q == ST_WAIT) && (sel_q == TGT_CLS);
   assign cls_we_o     = we_q;
   assign cls_addr_o   = addr_q;
   assign cls_wdata_o  = wdata_q;

   always_comb begin
      for (int i = 0; i < `ISL_NUM_INIT; i++) begin
         init_rsp_o[i] = (state_q == ST_RESP) && (idx_q == init_idx_t'(i));
      end
   end

   assign init_err_o   = init_rsp_o & {`ISL_NUM_INIT{sel_q == TGT_NONE}};
   assign init_rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: design/rr_arbiter.sv
// Round-robin arbiter
// Combinational one-hot grant over the request levels, with
// priority starting after the last winner. The pointer moves
// on the grant edge and holds while disabled.

`default_nettype none

`include "island_defines.svh"

module rr_arbiter #(
   parameter int unsigned NumReq = `ISL_NUM_INIT
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              en_i,
   input  logic [NumReq-1:0] req_i,
   output logic [NumReq-1:0] gnt_o
);

   import island_pkg::*;

   init_idx_t last_q;
   init_idx_t win_idx;

   //////////////////////////////////////////////////
   // Grant selection
   //////////////////////////////////////////////////

   always_comb begin
      init_idx_t cand;
      logic      found;
      gnt_o   = '0;
      win_idx = last_q;
      found   = 1'b0;
      cand    = '0;
      if (en_i) begin
         // Scan starting one past the last winner
         for (int i = 1; i <= NumReq; i++) begin
            cand = init_idx_t'((int'(last_q) + i) % NumReq);
            if (!found && req_i[cand]) begin
               gnt_o[cand] = 1'b1;
               win_idx     = cand;
               found       = 1'b1;
            end
         end
      end
   end

   // Start so that requester 0 wins first
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         last_q <= init_idx_t'(NumReq - 1);
      end else if (|gnt_o) begin
         last_q <= win_idx;
      end
   end

endmodule

`default_nettype wire

// File: design/addr_decoder.sv
// Address decoder
// Matches a request address against the host and cluster
// rules and returns the target, or TGT_NONE on a miss

`default_nettype none

`include "island_defines.svh"

module addr_decoder (
   input  island_pkg::addr_t    addr_i,
   output island_pkg::tgt_sel_e sel_o
);

   import island_pkg::*;

   localparam addr_t HostBase = `ISL_HOST_BASE;
   localparam addr_t HostEnd  = `ISL_HOST_END;
   localparam addr_t ClsBase  = `ISL_CLS_BASE;
   localparam addr_t ClsEnd   = `ISL_CLS_END;

   logic host_hit;
   logic cls_hit;

   // Base inclusive, end exclusive
   assign host_hit = (addr_i >= HostBase) && (addr_i < HostEnd);
   assign cls_hit  = (addr_i >= ClsBase) && (addr_i < ClsEnd);

   always_comb begin
      if (host_hit) begin
         sel_o = TGT_HOST;
      end else if (cls_hit) begin
         sel_o = TGT_CLS;
      end else begin
         // Below host base, in the gap, or past cluster end
         sel_o = TGT_NONE;
      end
   end

endmodule

`default_nettype wire

// File: design/bit_sync.sv
// Level synchronizer
// Chain of flops bringing an asynchronous level input into
// the clock domain, read at the last stage

`default_nettype none

module bit_sync #(
   parameter int unsigned Stages     = 2,
   parameter logic        ResetValue = 1'b0
) (
   input  logic clk_i,
   input  logic rst_i,
   input  logic d_i,
   output logic q_o
);

   logic [Stages-1:0] sync_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sync_q <= {Stages{ResetValue}};
      end else begin
         sync_q[0] <= d_i;
         for (int i = 1; i < Stages; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // Input delayed by exactly Stages edges
   assign q_o = sync_q[Stages-1];

endmodule

`default_nettype wire

// File: design/island_pkg.sv
// Security island types
// Address and data words, initiator index and the target
// select produced by the address decoder

`default_nettype none

`include "island_defines.svh"

package island_pkg;

   // Bus address
   typedef logic [`ISL_ADDR_W-1:0] addr_t;

   // Data word
   typedef logic [`ISL_DATA_W-1:0] data_t;

   // Index of one initiator
   typedef logic [$clog2(`ISL_NUM_INIT)-1:0] init_idx_t;

   // Routing target
   typedef enum logic [1:0] {
      TGT_HOST,
      TGT_CLS,
      TGT_NONE
   } tgt_sel_e;

endpackage

`default_nettype wire

// File: design/island_defines.svh
// Security island configuration
// Bus widths, initiator count, synchronizer depth and the
// two address rules of the system-side crossbar

`ifndef ISLAND_DEFINES_SVH
`define ISLAND_DEFINES_SVH

// Bus widths
`define ISL_ADDR_W        32
`define ISL_DATA_W        32

// Root-of-trust initiators, bridge port and DMA port
`define ISL_NUM_INIT      2

// Flops in each input synchronizer
`define ISL_SYNC_STAGES   3

// Host rule, base inclusive and end exclusive
`define ISL_HOST_BASE     32'h0001_0000
`define ISL_HOST_END      32'hA000_0000

// Cluster rule, same convention
`define ISL_CLS_BASE      32'hA100_0000
`define ISL_CLS_END       32'hB000_0000

`endif
